// File: hdl/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data and address width of the core
`define LSU_GRLEN 32

// width of the lsu_op code from the core
`define LSU_OP_BITS 4

// destination register index
`define LSU_RD_BITS 5

// one strobe per byte of a data word
`define LSU_WSTRB_BITS 4

`endif

// File: hdl/lsu_pkg.sv
`include "lsu_consts.svh"

package lsu_pkg;

   // operation codes dispatched by the core at _e
   typedef enum logic [`LSU_OP_BITS-1:0] {
      LSU_NOP   = 4'd0,
      LSU_LD_B  = 4'd1,
      LSU_LD_BU = 4'd2,
      LSU_LD_H  = 4'd3,
      LSU_LD_HU = 4'd4,
      LSU_LD_W  = 4'd5,
      LSU_ST_B  = 4'd6,
      LSU_ST_H  = 4'd7,
      LSU_ST_W  = 4'd8,
      LSU_LL_W  = 4'd9,
      LSU_SC_W  = 4'd10,
      LSU_PRELD = 4'd11
   } lsu_op_e;

   // access size of a memory operation
   typedef enum logic [1:0] {
      SIZE_B = 2'd0,
      SIZE_H = 2'd1,
      SIZE_W = 2'd2
   } mem_size_e;

endpackage

// File: hdl/lsu_op_decode.sv
`timescale 1ns/100ps

module lsu_op_decode (
   input  lsu_pkg::lsu_op_e   op,
   output lsu_pkg::mem_size_e size,
   output logic               unsigned_ld,
   output logic               is_load,
   output logic               is_store,
   output logic               is_ll,
   output logic               is_sc,
   output logic               is_prefetch
);
   import lsu_pkg::*;

   always_comb begin
      size        = SIZE_B;
      unsigned_ld = 1'b0;
      is_load     = 1'b0;
      is_store    = 1'b0;
      is_ll       = 1'b0;
      is_sc       = 1'b0;
      is_prefetch = 1'b0;
      case (op)
         LSU_LD_B: is_load = 1'b1;
         LSU_LD_BU: begin
            is_load     = 1'b1;
            unsigned_ld = 1'b1;
         end
         LSU_LD_H: begin
            size    = SIZE_H;
            is_load = 1'b1;
         end
         LSU_LD_HU: begin
            size        = SIZE_H;
            is_load     = 1'b1;
            unsigned_ld = 1'b1;
         end
         LSU_LD_W: begin
            size    = SIZE_W;
            is_load = 1'b1;
         end
         LSU_ST_B: is_store = 1'b1;
         LSU_ST_H: begin
            size     = SIZE_H;
            is_store = 1'b1;
         end
         LSU_ST_W: begin
            size     = SIZE_W;
            is_store = 1'b1;
         end
         // ll is a word load that also sets the link
         LSU_LL_W: begin
            size    = SIZE_W;
            is_load = 1'b1;
            is_ll   = 1'b1;
         end
         LSU_SC_W: begin
            size     = SIZE_W;
            is_store = 1'b1;
            is_sc    = 1'b1;
         end
         // prefetch goes out as a byte load hint
         LSU_PRELD: begin
            is_load     = 1'b1;
            is_prefetch = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

// File: hdl/lsu_req_gen.sv
`timescale 1ns/100ps

`include "lsu_consts.svh"

module lsu_req_gen (
   input  logic                       valid_e,
   input  logic [`LSU_GRLEN-1:0]      base,
   input  logic [`LSU_GRLEN-1:0]      offset,
   input  logic [`LSU_GRLEN-1:0]      wdata,
   input  lsu_pkg::mem_size_e         size,
   input  logic                       is_store,
   input  logic                       is_ll,
   input  logic                       is_sc,
   output logic                       data_req,
   output logic [`LSU_GRLEN-1:0]      data_addr,
   output logic                       data_wr,
   output logic [`LSU_WSTRB_BITS-1:0] data_wstrb,
   output logic [`LSU_GRLEN-1:0]      data_wdata,
   output logic                       ale
);
   import lsu_pkg::*;

   logic [`LSU_GRLEN-1:0] addr;
   logic                  half_mis;
   logic                  word_mis;

   assign addr = base + offset;

   // halfwords need an even address, words (ll/sc too) a multiple of four
   assign half_mis = (size == SIZE_H) && addr[0];
   assign word_mis = ((size == SIZE_W) || is_ll || is_sc) && (addr[1:0] != 2'b00);
   assign ale      = half_mis || word_mis;

   // no request leaves the LSU on an alignment exception
   assign data_req  = valid_e && !ale;
   assign data_addr = addr;
   assign data_wr   = is_store;

   always_comb begin
      case (size)
         SIZE_W: begin
            data_wstrb = 4'b1111;
            data_wdata = wdata;
         end
         SIZE_H: begin
            data_wstrb = 4'b0011 << addr[1:0];
            data_wdata = {2{wdata[15:0]}};
         end
         SIZE_B: begin
            data_wstrb = 4'b0001 << addr[1:0];
            data_wdata = {4{wdata[7:0]}};
         end
         default: begin
            data_wstrb = '0;
            data_wdata = wdata;
         end
      endcase
   end

endmodule

// File: hdl/lsu_stage_m.sv
`timescale 1ns/100ps

`include "lsu_consts.svh"

module lsu_stage_m (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    valid_e,
   input  logic                    ale,
   input  lsu_pkg::mem_size_e      size,
   input  logic                    unsigned_ld,
   input  logic                    is_sc,
   input  logic [1:0]              addr_lo,
   input  logic [`LSU_RD_BITS-1:0] ecl_lsu_rd_e,
   input  logic                    ecl_lsu_wen_e,
   input  logic                    data_addr_ok,
   input  logic                    data_data_ok,
   output lsu_pkg::mem_size_e      size_m,
   output logic                    unsigned_m,
   output logic                    sc_m,
   output logic [1:0]              shift_m,
   output logic                    lsu_finish_m,
   output logic [`LSU_RD_BITS-1:0] lsu_ecl_rd_m,
   output logic                    lsu_ecl_wen_m,
   output logic                    data_recv
);

   logic valid_m;
   logic ale_m;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_m <= 1'b0;
         ale_m   <= 1'b0;
      end else begin
         valid_m <= valid_e;
         ale_m   <= ale;
      end
   end

   // decoded fields follow the operation into _m
   always_ff @(posedge clk) begin
      if (valid_e) begin
         size_m        <= size;
         unsigned_m    <= unsigned_ld;
         sc_m          <= is_sc;
         shift_m       <= addr_lo;
         lsu_ecl_rd_m  <= ecl_lsu_rd_e;
         lsu_ecl_wen_m <= ecl_lsu_wen_e;
      end
   end

   // outstanding request, from address accept until data return
   always_ff @(posedge clk) begin
      if (reset) begin
         data_recv <= 1'b0;
      end else begin
         data_recv <= (data_recv || data_addr_ok) && !data_data_ok;
      end
   end

   // a misaligned op finishes the cycle after it was dispatched
   assign lsu_finish_m = data_data_ok || (ale_m && valid_m);

   a_data_ok_outstanding: assert property (@(posedge clk) disable iff (reset)
      data_data_ok |-> data_recv)
      else $error("data_data_ok without an outstanding request");

endmodule

// File: hdl/lsu_load_align.sv
`timescale 1ns/100ps

`include "lsu_consts.svh"

module lsu_load_align (
   input  logic [`LSU_GRLEN-1:0] data_rdata,
   input  logic                  data_scsucceed,
   input  lsu_pkg::mem_size_e    size_m,
   input  logic                  unsigned_m,
   input  logic                  sc_m,
   input  logic [1:0]            shift_m,
   output logic [`LSU_GRLEN-1:0] read_result_m
);
   import lsu_pkg::*;

   logic [7:0]  byte_sel;
   logic [15:0] half_sel;

   // pick the addressed lane out of the returned word
   always_comb begin
      case (shift_m)
         2'd0: byte_sel = data_rdata[7:0];
         2'd1: byte_sel = data_rdata[15:8];
         2'd2: byte_sel = data_rdata[23:16];
         default: byte_sel = data_rdata[31:24];
      endcase
   end

   assign half_sel = shift_m[1] ? data_rdata[31:16] : data_rdata[15:0];

   always_comb begin
      if (sc_m) begin
         // sc writes back only the success flag
         read_result_m = {{(`LSU_GRLEN-1){1'b0}}, data_scsucceed};
      end else begin
         case (size_m)
            SIZE_B: read_result_m = {{24{!unsigned_m && byte_sel[7]}}, byte_sel};
            SIZE_H: read_result_m = {{16{!unsigned_m && half_sel[15]}}, half_sel};
            default: read_result_m = data_rdata;
         endcase
      end
   end

endmodule

// File: hdl/lsu.sv
`timescale 1ns/100ps

`include "lsu_consts.svh"

module lsu (
   input  logic                       clk,
   input  logic                       reset,

   // core side, _e stage
   input  logic                       valid_e,
   input  lsu_pkg::lsu_op_e           lsu_op,
   input  logic [`LSU_GRLEN-1:0]      base,
   input  logic [`LSU_GRLEN-1:0]      offset,
   input  logic [`LSU_GRLEN-1:0]      wdata,
   input  logic [`LSU_RD_BITS-1:0]    ecl_lsu_rd_e,
   input  logic                       ecl_lsu_wen_e,
   output logic                       lsu_addr_finish,
   output logic                       lsu_ecl_ale_e,

   // core side, _m stage
   output logic [`LSU_GRLEN-1:0]      read_result_m,
   output logic                       lsu_finish_m,
   output logic [`LSU_RD_BITS-1:0]    lsu_ecl_rd_m,
   output logic                       lsu_ecl_wen_m,

   // memory side
   output logic                       data_req,
   output logic [`LSU_GRLEN-1:0]      data_addr,
   output logic                       data_wr,
   output logic [`LSU_WSTRB_BITS-1:0] data_wstrb,
   output logic [`LSU_GRLEN-1:0]      data_wdata,
   output logic                       data_prefetch,
   output logic                       data_ll,
   output logic                       data_sc,
   output logic                       data_recv,
   input  logic                       data_addr_ok,
   input  logic                       data_data_ok,
   input  logic [`LSU_GRLEN-1:0]      data_rdata,
   input  logic                       data_scsucceed
);
   import lsu_pkg::*;

   mem_size_e  size;
   mem_size_e  size_m;
   logic       unsigned_ld;
   logic       unsigned_m;
   logic       is_load;
   logic       is_store;
   logic       is_ll;
   logic       is_sc;
   logic       is_prefetch;
   logic       sc_m;
   logic [1:0] shift_m;
   logic       ale;

   lsu_op_decode u_decode (
      .op          (lsu_op),
      .size        (size),
      .unsigned_ld (unsigned_ld),
      .is_load     (is_load),
      .is_store    (is_store),
      .is_ll       (is_ll),
      .is_sc       (is_sc),
      .is_prefetch (is_prefetch)
   );

   lsu_req_gen u_req (
      .valid_e    (valid_e),
      .base       (base),
      .offset     (offset),
      .wdata      (wdata),
      .size       (size),
      .is_store   (is_store),
      .is_ll      (is_ll),
      .is_sc      (is_sc),
      .data_req   (data_req),
      .data_addr  (data_addr),
      .data_wr    (data_wr),
      .data_wstrb (data_wstrb),
      .data_wdata (data_wdata),
      .ale        (ale)
   );

   lsu_stage_m u_stage (
      .clk           (clk),
      .reset         (reset),
      .valid_e       (valid_e),
      .ale           (ale),
      .size          (size),
      .unsigned_ld   (unsigned_ld),
      .is_sc         (is_sc),
      .addr_lo       (data_addr[1:0]),
      .ecl_lsu_rd_e  (ecl_lsu_rd_e),
      .ecl_lsu_wen_e (ecl_lsu_wen_e),
      .data_addr_ok  (data_addr_ok),
      .data_data_ok  (data_data_ok),
      .size_m        (size_m),
      .unsigned_m    (unsigned_m),
      .sc_m          (sc_m),
      .shift_m       (shift_m),
      .lsu_finish_m  (lsu_finish_m),
      .lsu_ecl_rd_m  (lsu_ecl_rd_m),
      .lsu_ecl_wen_m (lsu_ecl_wen_m),
      .data_recv     (data_recv)
   );

   lsu_load_align u_align (
      .data_rdata     (data_rdata),
      .data_scsucceed (data_scsucceed),
      .size_m         (size_m),
      .unsigned_m     (unsigned_m),
      .sc_m           (sc_m),
      .shift_m        (shift_m),
      .read_result_m  (read_result_m)
   );

   assign data_prefetch = is_prefetch;
   assign data_ll       = is_ll;
   assign data_sc       = is_sc;

   // exception is only meaningful alongside a dispatch
   assign lsu_ecl_ale_e   = ale && valid_e;
   assign lsu_addr_finish = valid_e && (ale || data_addr_ok);

   // the core only dispatches real memory operations
   a_valid_op: assert property (@(posedge clk) disable iff (reset)
      valid_e |-> (is_load || is_store))
      else $error("valid_e with an opcode that is neither load nor store");

endmodule

// File: testbench/tb_lsu.sv
`timescale 1ns/100ps

`include "lsu_consts.svh"

module tb_lsu;
   import lsu_pkg::*;

   localparam int NUM_OPS       = 66;
   localparam int RESET_CYCLES  = 5;
   localparam int WATCHDOG_TIME = (NUM_OPS * 10 + RESET_CYCLES) * 20;

   logic                       clk;
   logic                       reset;
   logic                       valid_e;
   lsu_op_e                    lsu_op;
   logic [`LSU_GRLEN-1:0]      base;
   logic [`LSU_GRLEN-1:0]      offset;
   logic [`LSU_GRLEN-1:0]      wdata;
   logic [`LSU_RD_BITS-1:0]    ecl_lsu_rd_e;
   logic                       ecl_lsu_wen_e;
   logic                       lsu_addr_finish;
   logic                       lsu_ecl_ale_e;
   logic [`LSU_GRLEN-1:0]      read_result_m;
   logic                       lsu_finish_m;
   logic [`LSU_RD_BITS-1:0]    lsu_ecl_rd_m;
   logic                       lsu_ecl_wen_m;
   logic                       data_req;
   logic [`LSU_GRLEN-1:0]      data_addr;
   logic                       data_wr;
   logic [`LSU_WSTRB_BITS-1:0] data_wstrb;
   logic [`LSU_GRLEN-1:0]      data_wdata;
   logic                       data_prefetch;
   logic                       data_ll;
   logic                       data_sc;
   logic                       data_recv;
   logic                       data_addr_ok;
   logic                       data_data_ok;
   logic [`LSU_GRLEN-1:0]      data_rdata;
   logic                       data_scsucceed;

   // memory model state
   logic [7:0] mem [0:1023];
   logic       sc_flag;
   int         req_count;

   // values seen during the last operation
   logic                       snap_req;
   logic                       snap_wr;
   logic                       snap_ll;
   logic                       snap_sc;
   logic                       snap_pf;
   logic                       snap_ale;
   logic                       snap_afin;
   logic                       snap_fin_e;
   logic [`LSU_WSTRB_BITS-1:0] snap_wstrb;
   logic [`LSU_GRLEN-1:0]      res;
   logic [`LSU_GRLEN-1:0]      ext_word;
   int                         errors;
   int                         ops;

   lsu DUT (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      for (int i = 0; i < 1024; i++) begin
         mem[i] = i[7:0] ^ {4{i[9:8]}};
      end
   end

   // accepts every request at once, returns data one cycle later
   assign data_addr_ok = data_req;

   always @(posedge clk) begin : mem_model
      logic        hit;
      logic [9:0]  a;
      logic [31:0] word;
      hit = data_req && data_addr_ok;
      a   = {data_addr[9:2], 2'b00};
      if (hit) begin
         req_count = req_count + 1;
         if (data_wr) begin
            for (int k = 0; k < 4; k++) begin
               if (data_wstrb[k])
                  mem[a + k] = data_wdata[8*k +: 8];
            end
         end
      end
      word = {mem[a + 3], mem[a + 2], mem[a + 1], mem[a]};
      #2;
      data_data_ok   = hit;
      data_rdata     = hit ? word : '0;
      data_scsucceed = hit && sc_flag;
   end

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
      errors++;
   endtask

   task automatic report_failure(input string what);
      $display("%s at %0t", what, $time);
      errors++;
   endtask

   // called 2 ns after a rising edge, returns at the same point
   task automatic run_op(input lsu_op_e op, input logic [31:0] b, input logic [31:0] off,
                         input logic [31:0] wd, input logic exp_ale);
      int                      cycles;
      int                      count_before;
      logic [`LSU_RD_BITS-1:0] rd;
      logic                    wen;
      logic                    recv_during;
      logic                    ok_at_fin;
      rd           = 5'($urandom);
      wen          = 1'($urandom);
      count_before = req_count;
      ops++;
      valid_e       = 1'b1;
      lsu_op        = op;
      base          = b;
      offset        = off;
      wdata         = wd;
      ecl_lsu_rd_e  = rd;
      ecl_lsu_wen_e = wen;
      @(negedge clk);
      snap_fin_e = lsu_finish_m;
      cycles = 0;
      while (!lsu_addr_finish && cycles < 10) begin
         @(negedge clk);
         cycles++;
      end
      if (!lsu_addr_finish)
         report_failure("address phase never finished");
      snap_req   = data_req;
      snap_wr    = data_wr;
      snap_wstrb = data_wstrb;
      snap_ll    = data_ll;
      snap_sc    = data_sc;
      snap_pf    = data_prefetch;
      snap_ale   = lsu_ecl_ale_e;
      snap_afin  = lsu_addr_finish;
      @(posedge clk);
      #2;
      valid_e = 1'b0;
      lsu_op  = LSU_NOP;
      @(negedge clk);
      cycles = 0;
      while (!lsu_finish_m && cycles < 10) begin
         @(negedge clk);
         cycles++;
      end
      if (!lsu_finish_m)
         report_failure("lsu_finish_m never rose");
      res         = read_result_m;
      recv_during = data_recv;
      ok_at_fin   = data_data_ok;
      if (lsu_ecl_rd_m !== rd)
         report_mismatch("lsu_ecl_rd_m", lsu_ecl_rd_m, rd);
      if (lsu_ecl_wen_m !== wen)
         report_mismatch("lsu_ecl_wen_m", lsu_ecl_wen_m, wen);
      if (snap_ale !== exp_ale)
         report_mismatch("lsu_ecl_ale_e", snap_ale, exp_ale);
      if (snap_afin !== 1'b1)
         report_mismatch("lsu_addr_finish", snap_afin, 1'b1);
      if (snap_fin_e !== 1'b0)
         report_mismatch("lsu_finish_m", snap_fin_e, 1'b0);
      if (exp_ale) begin
         if (snap_req !== 1'b0)
            report_mismatch("data_req", snap_req, 1'b0);
         if (req_count != count_before)
            report_failure("a misaligned access reached the memory");
         if (cycles != 0)
            report_failure("misaligned finish not one cycle after valid_e");
         if (recv_during !== 1'b0)
            report_mismatch("data_recv", recv_during, 1'b0);
      end else begin
         if (snap_req !== 1'b1)
            report_mismatch("data_req", snap_req, 1'b1);
         if (recv_during !== 1'b1)
            report_mismatch("data_recv", recv_during, 1'b1);
         if (ok_at_fin !== 1'b1)
            report_failure("lsu_finish_m high without data_data_ok");
      end
      @(negedge clk);
      if (lsu_finish_m !== 1'b0)
         report_mismatch("lsu_finish_m", lsu_finish_m, 1'b0);
      if (data_recv !== 1'b0)
         report_mismatch("data_recv", data_recv, 1'b0);
      @(posedge clk);
      #2;
   endtask

   task automatic store_load_test(input lsu_op_e st_op, input int off);
      logic [31:0] waddr;
      logic [31:0] old_word;
      logic [31:0] new_word;
      logic [31:0] exp_word;
      logic [3:0]  exp_strb;
      waddr    = {22'd0, 8'($urandom), 2'b00};
      old_word = $urandom;
      new_word = $urandom;
      exp_word = old_word;
      exp_strb = 4'b0000;
      // one strobe bit per byte lane that the store touches
      case (st_op)
         LSU_ST_B: begin
            exp_word[8*off +: 8] = new_word[7:0];
            exp_strb[off] = 1'b1;
         end
         LSU_ST_H: begin
            exp_word[8*off +: 16] = new_word[15:0];
            exp_strb[off]     = 1'b1;
            exp_strb[off + 1] = 1'b1;
         end
         default: begin
            exp_word = new_word;
            exp_strb = 4'b1111;
         end
      endcase
      run_op(LSU_ST_W, waddr - 32'd4, 32'd4, old_word, 1'b0);
      run_op(st_op, waddr, off, new_word, 1'b0);
      if (snap_wr !== 1'b1)
         report_mismatch("data_wr", snap_wr, 1'b1);
      if (snap_wstrb !== exp_strb)
         report_mismatch("data_wstrb", snap_wstrb, exp_strb);
      run_op(LSU_LD_W, waddr, 32'd0, 32'd0, 1'b0);
      if (res !== exp_word)
         report_mismatch("read_result_m", res, exp_word);
   endtask

   task automatic extend_test(input logic [31:0] word);
      logic [31:0] waddr;
      logic [7:0]  b;
      logic [15:0] h;
      waddr = {22'd0, 8'($urandom), 2'b00};
      run_op(LSU_ST_W, waddr, 32'd0, word, 1'b0);
      for (int off = 0; off < 4; off++) begin
         b = word[8*off +: 8];
         run_op(LSU_LD_B, waddr + off, 32'd0, 32'd0, 1'b0);
         if (res !== {{24{b[7]}}, b})
            report_mismatch("read_result_m", res, {{24{b[7]}}, b});
         run_op(LSU_LD_BU, waddr, off, 32'd0, 1'b0);
         if (res !== {24'd0, b})
            report_mismatch("read_result_m", res, {24'd0, b});
         if (off % 2 == 0) begin
            h = word[8*off +: 16];
            run_op(LSU_LD_H, waddr, off, 32'd0, 1'b0);
            if (res !== {{16{h[15]}}, h})
               report_mismatch("read_result_m", res, {{16{h[15]}}, h});
            run_op(LSU_LD_HU, waddr, off, 32'd0, 1'b0);
            if (res !== {16'd0, h})
               report_mismatch("read_result_m", res, {16'd0, h});
         end
      end
   endtask

   task automatic llsc_test();
      logic [31:0] waddr;
      logic [31:0] word;
      waddr = {22'd0, 8'($urandom), 2'b00};
      word  = $urandom;
      run_op(LSU_ST_W, waddr, 32'd0, word, 1'b0);
      run_op(LSU_LL_W, waddr, 32'd0, 32'd0, 1'b0);
      if (snap_ll !== 1'b1)
         report_mismatch("data_ll", snap_ll, 1'b1);
      if (res !== word)
         report_mismatch("read_result_m", res, word);
      sc_flag = 1'b1;
      run_op(LSU_SC_W, waddr, 32'd0, $urandom, 1'b0);
      if (snap_sc !== 1'b1)
         report_mismatch("data_sc", snap_sc, 1'b1);
      if (res !== 32'd1)
         report_mismatch("read_result_m", res, 32'd1);
      sc_flag = 1'b0;
      run_op(LSU_SC_W, waddr, 32'd0, $urandom, 1'b0);
      if (res !== 32'd0)
         report_mismatch("read_result_m", res, 32'd0);
   endtask

   initial begin
      void'($urandom(32'he931_194e));
      reset          = 1'b1;
      valid_e        = 1'b0;
      lsu_op         = LSU_NOP;
      base           = '0;
      offset         = '0;
      wdata          = '0;
      ecl_lsu_rd_e   = '0;
      ecl_lsu_wen_e  = 1'b0;
      data_data_ok   = 1'b0;
      data_rdata     = '0;
      data_scsucceed = 1'b0;
      sc_flag        = 1'b0;
      req_count      = 0;
      errors         = 0;
      ops            = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      reset = 1'b0;
      @(negedge clk);
      if (data_recv !== 1'b0)
         report_mismatch("data_recv", data_recv, 1'b0);
      if (lsu_finish_m !== 1'b0)
         report_mismatch("lsu_finish_m", lsu_finish_m, 1'b0);
      @(posedge clk);
      #2;

      store_load_test(LSU_ST_W, 0);
      for (int off = 0; off < 4; off += 2) begin
         store_load_test(LSU_ST_H, off);
      end
      for (int off = 0; off < 4; off++) begin
         store_load_test(LSU_ST_B, off);
      end

      // the complement gives every byte both sign values
      ext_word = $urandom;
      extend_test(ext_word);
      extend_test(~ext_word);

      run_op(LSU_LD_H, {22'd0, 8'($urandom), 2'b00}, 32'd1, 32'd0, 1'b1);
      run_op(LSU_LD_H, {22'd0, 8'($urandom), 2'b00}, 32'd3, 32'd0, 1'b1);
      for (int off = 1; off < 4; off++) begin
         run_op(LSU_LD_W, {22'd0, 8'($urandom), 2'b00}, off, 32'd0, 1'b1);
         run_op(LSU_LL_W, {22'd0, 8'($urandom), 2'b00}, off, 32'd0, 1'b1);
         run_op(LSU_ST_W, {22'd0, 8'($urandom), 2'b00}, off, $urandom, 1'b1);
         run_op(LSU_SC_W, {22'd0, 8'($urandom), 2'b00}, off, $urandom, 1'b1);
      end

      llsc_test();

      run_op(LSU_PRELD, {22'd0, 8'($urandom), 2'b00}, 32'd1, 32'd0, 1'b0);
      if (snap_pf !== 1'b1)
         report_mismatch("data_prefetch", snap_pf, 1'b1);
      if (snap_wr !== 1'b0)
         report_mismatch("data_wr", snap_wr, 1'b0);

      $display("operations %0d, errors %0d", ops, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_TIME);
      $display("watchdog expired before the tests completed");
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

// File: src.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_op_decode.sv
hdl/lsu_req_gen.sv
hdl/lsu_stage_m.sv
hdl/lsu_load_align.sv
hdl/lsu.sv
testbench/tb_lsu.sv

// File: Bender.yml
package:
  name: lsu

export_include_dirs:
  - hdl

sources:
  - hdl/lsu_pkg.sv
  - hdl/lsu_op_decode.sv
  - hdl/lsu_req_gen.sv
  - hdl/lsu_stage_m.sv
  - hdl/lsu_load_align.sv
  - hdl/lsu.sv
  - target: test
    files:
      - testbench/tb_lsu.sv
